// ==== flist.f ====
rtl/coco_glue_pkg.sv
rtl/option_decode.sv
rtl/joystick_router.sv
rtl/config_reset_ctrl.sv
rtl/tape_buffer.sv
rtl/tape_player.sv
rtl/coco_glue_top.sv
tb/tb_coco_glue.sv

// ==== rtl/coco_glue_pkg.sv ====
//==================================================
// CoCo3 glue shared definitions
//==================================================

package coco_glue_pkg;

	// Reset request handshake states
	typedef enum logic [1:0]
	{
		RST_IDLE,
		RST_REQ,
		RST_DROP
	} reset_state_t;

	// Multi-pak slot, as seen by the core
	typedef enum logic [1:0]
	{
		SLOT_1      = 2'd0,
		SLOT_2_SDC  = 2'd1,
		SLOT_3_CART = 2'd2,
		SLOT_4_DISK = 2'd3
	} mpi_slot_t;

	typedef enum logic [2:0]
	{
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_16M  = 3'd3
	} mem_size_t;

	localparam int STATUS_W = 64;

	//==================================================
	// Menu status bit positions
	//==================================================
	localparam int ST_RESET     = 0;
	localparam int ST_SCALE_LO  = 3;
	localparam int ST_SWAP_JOY  = 6;
	localparam int ST_AR_LO     = 8;
	localparam int ST_CPU_SPEED = 11;
	localparam int ST_MPI_LO    = 12;
	localparam int ST_VIDEO     = 14;
	localparam int ST_REWIND    = 15;
	localparam int ST_CARTINT   = 16;
	localparam int ST_TAPE_MON  = 17;
	localparam int ST_SG4V6     = 21;
	localparam int ST_COLDBOOT  = 22;
	localparam int ST_MEM_LO    = 25;
	localparam int ST_ART_LO    = 37;

	// Download index of a cassette image
	localparam logic [7:0] TAPE_INDEX = 8'd2;

	localparam int SWITCH_W      = 10;
	localparam int AUDIO_MON_BIT = 13;

endpackage

// ==== rtl/coco_glue_top.sv ====
//==================================================
// CoCo3 platform glue top level
//==================================================

`timescale 1ns/1ns

module coco_glue_top import coco_glue_pkg::*;
#(
	parameter int TAPE_ADDR_W = 16
)
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [STATUS_W-1:0] status,
	input  logic                user_button,
	input  logic [31:0]         joy1,
	input  logic [31:0]         joy2,
	input  logic [15:0]         joya1,
	input  logic [15:0]         joya2,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_data,
	input  logic [7:0]          ioctl_index,
	input  logic                cas_relay,
	input  logic                q_tick,
	input  logic [15:0]         audio_in,
	input  logic                reset_ack,
	output logic [SWITCH_W-1:0] switch_word,
	output logic [12:0]         video_arx,
	output logic [12:0]         video_ary,
	output logic [1:0]          vga_sl,
	output logic [31:0]         coco_joy1,
	output logic [31:0]         coco_joy2,
	output logic [15:0]         coco_ajoy1,
	output logic [15:0]         coco_ajoy2,
	output logic [3:0]          p_switch,
	output logic                reset_req,
	output logic                core_reset_n,
	output logic                tape_bit,
	output logic [15:0]         audio_out
);

	mpi_slot_t              mpi_slot;
	mem_size_t              mem_size;
	logic                   swap_joy;
	logic                   tape_monitor;
	logic                   tape_rewind;
	logic                   coldboot;
	logic                   host_reset_bit;
	logic [TAPE_ADDR_W-1:0] rd_addr;
	logic [7:0]             rd_data;
	logic                   tape_written;

	option_decode u_option_decode
	(
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.status         (status),
		.switch_word    (switch_word),
		.mpi_slot       (mpi_slot),
		.mem_size       (mem_size),
		.video_arx      (video_arx),
		.video_ary      (video_ary),
		.vga_sl         (vga_sl),
		.swap_joy       (swap_joy),
		.tape_monitor   (tape_monitor),
		.tape_rewind    (tape_rewind),
		.coldboot       (coldboot),
		.host_reset_bit (host_reset_bit)
	);

	joystick_router u_joystick_router
	(
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.swap_joy   (swap_joy),
		.joy1       (joy1),
		.joy2       (joy2),
		.joya1      (joya1),
		.joya2      (joya2),
		.coco_joy1  (coco_joy1),
		.coco_joy2  (coco_joy2),
		.coco_ajoy1 (coco_ajoy1),
		.coco_ajoy2 (coco_ajoy2),
		.p_switch   (p_switch)
	);

	config_reset_ctrl u_config_reset_ctrl
	(
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.mpi_slot       (mpi_slot),
		.mem_size       (mem_size),
		.coldboot       (coldboot),
		.host_reset_bit (host_reset_bit),
		.user_button    (user_button),
		.reset_ack      (reset_ack),
		.reset_req      (reset_req),
		.core_reset_n   (core_reset_n)
	);

	//==================================================
	// Cassette path
	//==================================================
	tape_buffer #(.TAPE_ADDR_W(TAPE_ADDR_W)) u_tape_buffer
	(
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_index    (ioctl_index),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.tape_written   (tape_written)
	);

	tape_player #(.TAPE_ADDR_W(TAPE_ADDR_W)) u_tape_player
	(
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.q_tick       (q_tick),
		.cas_relay    (cas_relay),
		.tape_rewind  (tape_rewind),
		.tape_written (tape_written),
		.rd_data      (rd_data),
		.tape_monitor (tape_monitor),
		.audio_in     (audio_in),
		.rd_addr      (rd_addr),
		.tape_bit     (tape_bit),
		.audio_out    (audio_out)
	);

endmodule

// ==== rtl/config_reset_ctrl.sv ====
//==================================================
// Configuration change and host reset
//==================================================

`timescale 1ns/1ns

module config_reset_ctrl import coco_glue_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  mpi_slot_t mpi_slot,
	input  mem_size_t mem_size,
	input  logic      coldboot,
	input  logic      host_reset_bit,
	input  logic      user_button,
	input  logic      reset_ack,
	output logic      reset_req,
	output logic      core_reset_n
);

	mpi_slot_t    slot_d;
	mem_size_t    mem_d;
	logic         coldboot_d;
	logic         first_slot_chg;
	logic         first_mem_chg;
	logic         slot_trig;
	logic         mem_trig;
	logic         cold_trig;
	logic         trigger;
	logic         pending;
	reset_state_t state;

	//==================================================
	// Change detection
	//==================================================
	// The first change after reset is the menu settling, not the user
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot_d         <= SLOT_1;
			mem_d          <= MEM_512K;
			coldboot_d     <= 1'b0;
			first_slot_chg <= 1'b0;
			first_mem_chg  <= 1'b0;
			slot_trig      <= 1'b0;
			mem_trig       <= 1'b0;
			cold_trig      <= 1'b0;
		end
		else
		begin
			slot_d     <= mpi_slot;
			mem_d      <= mem_size;
			coldboot_d <= coldboot;
			slot_trig  <= 1'b0;
			mem_trig   <= 1'b0;
			cold_trig  <= coldboot & ~coldboot_d;
			if (mpi_slot != slot_d)
			begin
				if (!first_slot_chg)
					first_slot_chg <= 1'b1;
				else
					slot_trig <= 1'b1;
			end
			if (mem_size != mem_d)
			begin
				if (!first_mem_chg)
					first_mem_chg <= 1'b1;
				else
					mem_trig <= 1'b1;
			end
		end
	end

	assign trigger = slot_trig | mem_trig | cold_trig;

	//==================================================
	// Four-phase request to the core
	//==================================================
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= RST_IDLE;
			pending <= 1'b0;
		end
		else
		begin
			case (state)
				RST_IDLE:
				begin
					if (trigger || pending)
					begin
						state   <= RST_REQ;
						pending <= 1'b0;
					end
				end
				RST_REQ:
				begin
					if (trigger)
						pending <= 1'b1;
					if (reset_ack)
						state <= RST_DROP;
				end
				RST_DROP:
				begin
					if (trigger)
						pending <= 1'b1;
					if (!reset_ack)
						state <= RST_IDLE;
				end
				default:
					state <= RST_IDLE;
			endcase
		end
	end

	assign reset_req = (state == RST_REQ);

	// Core held in reset while the menu bit or user button is pressed
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			core_reset_n <= 1'b1;
		else
			core_reset_n <= ~(host_reset_bit | user_button);
	end

endmodule

// ==== rtl/joystick_router.sv ====
//==================================================
// Joystick swap and analog centering
//==================================================

`timescale 1ns/1ns

module joystick_router
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        swap_joy,
	input  logic [31:0] joy1,
	input  logic [31:0] joy2,
	input  logic [15:0] joya1,
	input  logic [15:0] joya2,
	output logic [31:0] coco_joy1,
	output logic [31:0] coco_joy2,
	output logic [15:0] coco_ajoy1,
	output logic [15:0] coco_ajoy2,
	output logic [3:0]  p_switch
);

	logic [15:0] ajoy1_c;
	logic [15:0] ajoy2_c;

	// Signed -128..127 becomes unsigned 0..255 around mid scale
	assign ajoy1_c = {joya1[15:8] + 8'd128, joya1[7:0] + 8'd128};
	assign ajoy2_c = {joya2[15:8] + 8'd128, joya2[7:0] + 8'd128};

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			coco_joy1  <= '0;
			coco_joy2  <= '0;
			coco_ajoy1 <= 16'h8080;
			coco_ajoy2 <= 16'h8080;
		end
		else
		begin
			coco_joy1  <= swap_joy ? joy2 : joy1;
			coco_joy2  <= swap_joy ? joy1 : joy2;
			coco_ajoy1 <= swap_joy ? ajoy2_c : ajoy1_c;
			coco_ajoy2 <= swap_joy ? ajoy1_c : ajoy2_c;
		end
	end

	// Fire buttons, active low: R1, L2, R2, L1
	assign p_switch = ~{coco_joy2[4], coco_joy1[5], coco_joy2[5], coco_joy1[4]};

endmodule

// ==== rtl/option_decode.sv ====
//==================================================
// Menu status word decode
//==================================================

`timescale 1ns/1ns

module option_decode import coco_glue_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [STATUS_W-1:0] status,
	output logic [SWITCH_W-1:0] switch_word,
	output mpi_slot_t           mpi_slot,
	output mem_size_t           mem_size,
	output logic [12:0]         video_arx,
	output logic [12:0]         video_ary,
	output logic [1:0]          vga_sl,
	output logic                swap_joy,
	output logic                tape_monitor,
	output logic                tape_rewind,
	output logic                coldboot,
	output logic                host_reset_bit
);

	logic [1:0] slot_num;
	logic [1:0] ar;
	logic [2:0] scale;
	logic [2:0] sl;

	// Menu lists slots 2..4 first, so the field wraps by one
	assign slot_num = status[ST_MPI_LO +: 2] + 2'd1;
	assign ar       = status[ST_AR_LO +: 2];
	assign scale    = status[ST_SCALE_LO +: 3];
	assign sl       = (scale == 3'd0) ? 3'd0 : scale - 3'd1;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			switch_word    <= '0;
			mpi_slot       <= SLOT_1;
			mem_size       <= MEM_512K;
			video_arx      <= 13'd4;
			video_ary      <= 13'd3;
			vga_sl         <= 2'd0;
			swap_joy       <= 1'b0;
			tape_monitor   <= 1'b0;
			tape_rewind    <= 1'b0;
			coldboot       <= 1'b0;
			host_reset_bit <= 1'b0;
		end
		else
		begin
			// Bit 9 set swaps the serial ports in the core
			switch_word <= {2'b10, status[ST_ART_LO +: 2], status[ST_SG4V6],
				status[ST_CARTINT], status[ST_VIDEO], slot_num, status[ST_CPU_SPEED]};
			mpi_slot    <= mpi_slot_t'(slot_num);
			mem_size    <= mem_size_t'(status[ST_MEM_LO +: 3]);
			// Original aspect is 4:3, other settings select a preset
			video_arx   <= (ar == 2'd0) ? 13'd4 : {11'd0, ar - 2'd1};
			video_ary   <= (ar == 2'd0) ? 13'd3 : 13'd0;
			vga_sl      <= sl[1:0];
			swap_joy       <= status[ST_SWAP_JOY];
			tape_monitor   <= status[ST_TAPE_MON];
			tape_rewind    <= status[ST_REWIND];
			coldboot       <= status[ST_COLDBOOT];
			host_reset_bit <= status[ST_RESET];
		end
	end

endmodule

// ==== rtl/tape_buffer.sv ====
//==================================================
// Cassette image RAM
//==================================================

`timescale 1ns/1ns

module tape_buffer import coco_glue_pkg::*;
#(
	parameter int TAPE_ADDR_W = 16
)
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_data,
	input  logic [7:0]             ioctl_index,
	input  logic [TAPE_ADDR_W-1:0] rd_addr,
	output logic [7:0]             rd_data,
	output logic                   tape_written
);

	logic [7:0]             mem [0:(1 << TAPE_ADDR_W)-1];
	logic [TAPE_ADDR_W-1:0] ram_addr;
	logic                   wr_en;

	assign wr_en    = ioctl_download & ioctl_wr & (ioctl_index == TAPE_INDEX);
	// Download owns the port while it runs
	assign ram_addr = ioctl_download ? ioctl_addr[TAPE_ADDR_W-1:0] : rd_addr;

	always_ff @(posedge clk_sys)
	begin
		if (wr_en)
			mem[ram_addr] <= ioctl_data;
		rd_data <= mem[ram_addr];
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			tape_written <= 1'b0;
		else
			tape_written <= wr_en;
	end

endmodule

// ==== rtl/tape_player.sv ====
//==================================================
// Cassette playback and tape monitor
//==================================================

`timescale 1ns/1ns

module tape_player import coco_glue_pkg::*;
#(
	parameter int TAPE_ADDR_W = 16
)
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   q_tick,
	input  logic                   cas_relay,
	input  logic                   tape_rewind,
	input  logic                   tape_written,
	input  logic [7:0]             rd_data,
	input  logic                   tape_monitor,
	input  logic [15:0]            audio_in,
	output logic [TAPE_ADDR_W-1:0] rd_addr,
	output logic                   tape_bit,
	output logic [15:0]            audio_out
);

	logic [2:0] bit_idx;
	logic       accept;

	// Motor relay gates the tape, rewind holds it at the start
	assign accept = q_tick & cas_relay & ~tape_rewind;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_addr  <= '0;
			bit_idx  <= 3'd0;
			tape_bit <= 1'b0;
		end
		else if (tape_rewind || tape_written)
		begin
			rd_addr  <= '0;
			bit_idx  <= 3'd0;
			tape_bit <= 1'b0;
		end
		else if (accept)
		begin
			// MSB first
			tape_bit <= rd_data[3'd7 - bit_idx];
			if (bit_idx == 3'd7)
			begin
				bit_idx <= 3'd0;
				rd_addr <= rd_addr + 1'b1;
			end
			else
				bit_idx <= bit_idx + 3'd1;
		end
	end

	always_comb
	begin
		audio_out = audio_in;
		audio_out[AUDIO_MON_BIT] = audio_in[AUDIO_MON_BIT] ^ (tape_monitor & tape_bit);
	end

endmodule

// ==== tb/tb_coco_glue.sv ====
//==================================================
// CoCo3 glue directed testbench
//==================================================

`timescale 1ns/1ns

module tb_coco_glue import coco_glue_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	// Rough cycle budget per test, used by the watchdog
	localparam int CYC_RESET  = 8;
	localparam int CYC_DECODE = 20;
	localparam int CYC_JOY    = 12;
	localparam int CYC_CONFIG = 200;
	localparam int CYC_HOST   = 24;
	localparam int CYC_TAPE   = 140;
	localparam int CYC_MON    = 24;
	localparam int CYC_MARGIN = 200;
	localparam int WATCHDOG_NS = (CYC_RESET + CYC_DECODE + CYC_JOY + CYC_CONFIG + CYC_HOST
		+ CYC_TAPE + CYC_MON + CYC_MARGIN) * CLK_PERIOD;

	logic                clk_sys;
	logic                rst_n;
	logic [STATUS_W-1:0] status;
	logic                user_button;
	logic [31:0]         joy1;
	logic [31:0]         joy2;
	logic [15:0]         joya1;
	logic [15:0]         joya2;
	logic                ioctl_download;
	logic                ioctl_wr;
	logic [24:0]         ioctl_addr;
	logic [7:0]          ioctl_data;
	logic [7:0]          ioctl_index;
	logic                cas_relay;
	logic                q_tick;
	logic [15:0]         audio_in;
	logic                reset_ack;
	logic [SWITCH_W-1:0] switch_word;
	logic [12:0]         video_arx;
	logic [12:0]         video_ary;
	logic [1:0]          vga_sl;
	logic [31:0]         coco_joy1;
	logic [31:0]         coco_joy2;
	logic [15:0]         coco_ajoy1;
	logic [15:0]         coco_ajoy2;
	logic [3:0]          p_switch;
	logic                reset_req;
	logic                core_reset_n;
	logic                tape_bit;
	logic [15:0]         audio_out;

	integer     seed;
	int         errors;
	int         checks;
	logic [7:0] tape_bytes [0:2];
	logic       exp_tape;

	coco_glue_top #(.TAPE_ADDR_W(16)) uut
	(
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.status         (status),
		.user_button    (user_button),
		.joy1           (joy1),
		.joy2           (joy2),
		.joya1          (joya1),
		.joya2          (joya2),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_index    (ioctl_index),
		.cas_relay      (cas_relay),
		.q_tick         (q_tick),
		.audio_in       (audio_in),
		.reset_ack      (reset_ack),
		.switch_word    (switch_word),
		.video_arx      (video_arx),
		.video_ary      (video_ary),
		.vga_sl         (vga_sl),
		.coco_joy1      (coco_joy1),
		.coco_joy2      (coco_joy2),
		.coco_ajoy1     (coco_ajoy1),
		.coco_ajoy2     (coco_ajoy2),
		.p_switch       (p_switch),
		.reset_req      (reset_req),
		.core_reset_n   (core_reset_n),
		.tape_bit       (tape_bit),
		.audio_out      (audio_out)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//==================================================
	// Helpers
	//==================================================
	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Wait n rising edges, then sample on the falling edge
	task automatic settle(input int n);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic finish_test(input string name, input int err0);
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	// Signed axis byte plus 128, modulo 256
	function automatic logic [15:0] center_axes(input logic [15:0] raw);
		int x;
		int y;
		x = (int'(raw[7:0]) + 128) % 256;
		y = (int'(raw[15:8]) + 128) % 256;
		return {y[7:0], x[7:0]};
	endfunction

	task automatic no_req_for(input int n, input string what);
		repeat (n)
		begin
			@(negedge clk_sys);
			checks++;
			if (reset_req !== 1'b0)
			begin
				errors++;
				$display("mismatch at %0t: reset_req high after %s", $time, what);
			end
		end
	endtask

	task automatic handshake(input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (reset_req !== 1'b1 && n < 20)
		begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		if (reset_req !== 1'b1)
		begin
			errors++;
			$display("reset_req never rose after %s", what);
		end
		else
		begin
			@(posedge clk_sys);
			reset_ack <= 1'b1;
			n = 0;
			@(negedge clk_sys);
			while (reset_req !== 1'b0 && n < 20)
			begin
				@(negedge clk_sys);
				n++;
			end
			checks++;
			if (reset_req !== 1'b0)
			begin
				errors++;
				$display("reset_req did not drop after reset_ack for %s", what);
			end
			@(posedge clk_sys);
			reset_ack <= 1'b0;
		end
		no_req_for(4, {what, " handshake"});
	endtask

	// Q ticks stay three cycles apart
	task automatic pulse_tick();
		@(posedge clk_sys);
		@(posedge clk_sys);
		q_tick <= 1'b1;
		@(posedge clk_sys);
		q_tick <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic play_bit(input int k);
		pulse_tick();
		exp_tape = tape_bytes[k / 8][7 - (k % 8)];
		check_val("tape_bit", tape_bit, exp_tape);
	endtask

	task automatic check_audio(input logic mon);
		logic [15:0] exp;
		exp = audio_in;
		if (mon && exp_tape)
			exp[AUDIO_MON_BIT] = ~exp[AUDIO_MON_BIT];
		check_val("audio_out", audio_out, exp);
	endtask

	//==================================================
	// Tests
	//==================================================
	task automatic test_status_decode();
		int          err0;
		int          i;
		int          sl;
		logic [31:0] rnd;
		logic [1:0]  ar;
		logic [2:0]  scale;
		logic [1:0]  slot;
		logic [9:0]  exp_sw;
		err0 = errors;
		slot = 2'((int'(status[ST_MPI_LO +: 2]) + 1) % 4);
		for (i = 0; i < 4; i++)
		begin
			rnd   = $random(seed);
			ar    = i[1:0];
			scale = (i == 0) ? 3'd0 : rnd[2:0];
			@(posedge clk_sys);
			status[ST_AR_LO +: 2]    <= ar;
			status[ST_SCALE_LO +: 3] <= scale;
			status[ST_CPU_SPEED]     <= rnd[3];
			status[ST_VIDEO]         <= rnd[4];
			status[ST_CARTINT]       <= rnd[5];
			status[ST_SG4V6]         <= rnd[6];
			status[ST_ART_LO +: 2]   <= rnd[8:7];
			settle(2);
			exp_sw = {2'b10, rnd[8:7], rnd[6], rnd[5], rnd[4], slot, rnd[3]};
			check_val("switch_word", switch_word, exp_sw);
			check_val("video_arx", video_arx, (ar == 0) ? 13'd4 : 13'(ar - 1));
			check_val("video_ary", video_ary, (ar == 0) ? 13'd3 : 13'd0);
			sl = (scale == 0) ? 0 : int'(scale) - 1;
			check_val("vga_sl", vga_sl, sl[1:0]);
		end
		finish_test("status decode", err0);
	endtask

	task automatic test_joystick();
		int          err0;
		int          sw;
		logic [31:0] j1;
		logic [31:0] j2;
		logic [15:0] a1;
		logic [15:0] a2;
		logic [31:0] ej1;
		logic [31:0] ej2;
		logic [3:0]  ep;
		err0 = errors;
		for (sw = 0; sw < 2; sw++)
		begin
			j1 = $random(seed);
			j2 = $random(seed);
			a1 = $random(seed);
			a2 = $random(seed);
			@(posedge clk_sys);
			status[ST_SWAP_JOY] <= sw[0];
			joy1  <= j1;
			joy2  <= j2;
			joya1 <= a1;
			joya2 <= a2;
			settle(2);
			ej1 = sw ? j2 : j1;
			ej2 = sw ? j1 : j2;
			ep  = ~{ej2[4], ej1[5], ej2[5], ej1[4]};
			check_val("coco_joy1", coco_joy1, ej1);
			check_val("coco_joy2", coco_joy2, ej2);
			check_val("coco_ajoy1", coco_ajoy1, center_axes(sw ? a2 : a1));
			check_val("coco_ajoy2", coco_ajoy2, center_axes(sw ? a1 : a2));
			check_val("p_switch", p_switch, ep);
		end
		@(posedge clk_sys);
		status[ST_SWAP_JOY] <= 1'b0;
		finish_test("joystick routing", err0);
	endtask

	task automatic test_config_reset();
		int err0;
		err0 = errors;
		// Menu field 3 maps to slot 1, so field 0 is the first real change
		@(posedge clk_sys);
		status[ST_MPI_LO +: 2] <= 2'd0;
		no_req_for(8, "first slot change");
		@(posedge clk_sys);
		status[ST_MPI_LO +: 2] <= 2'd1;
		handshake("second slot change");
		@(posedge clk_sys);
		status[ST_MEM_LO +: 3] <= 3'd1;
		no_req_for(8, "first memory change");
		@(posedge clk_sys);
		status[ST_MEM_LO +: 3] <= 3'd2;
		handshake("second memory change");
		@(posedge clk_sys);
		status[ST_COLDBOOT] <= 1'b1;
		handshake("cold boot edge");
		@(posedge clk_sys);
		status[ST_COLDBOOT] <= 1'b0;
		no_req_for(8, "cold boot release");
		finish_test("configuration reset", err0);
	endtask

	task automatic test_host_reset();
		int err0;
		err0 = errors;
		@(posedge clk_sys);
		status[ST_RESET] <= 1'b1;
		settle(2);
		check_val("core_reset_n", core_reset_n, 1'b0);
		settle(3);
		check_val("core_reset_n", core_reset_n, 1'b0);
		@(posedge clk_sys);
		status[ST_RESET] <= 1'b0;
		settle(2);
		check_val("core_reset_n", core_reset_n, 1'b1);
		@(posedge clk_sys);
		user_button <= 1'b1;
		settle(1);
		check_val("core_reset_n", core_reset_n, 1'b0);
		settle(3);
		check_val("core_reset_n", core_reset_n, 1'b0);
		@(posedge clk_sys);
		user_button <= 1'b0;
		settle(1);
		check_val("core_reset_n", core_reset_n, 1'b1);
		finish_test("host reset", err0);
	endtask

	task automatic test_tape_playback();
		int err0;
		int i;
		err0 = errors;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= TAPE_INDEX;
		for (i = 0; i < 3; i++)
		begin
			@(posedge clk_sys);
			ioctl_addr <= 25'(i);
			ioctl_data <= tape_bytes[i];
			ioctl_wr   <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr   <= 1'b0;
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		cas_relay      <= 1'b1;
		settle(2);
		for (i = 0; i < 12; i++)
			play_bit(i);
		// Relay off holds the tape where it is
		@(posedge clk_sys);
		cas_relay <= 1'b0;
		for (i = 0; i < 3; i++)
		begin
			pulse_tick();
			check_val("tape_bit (relay off)", tape_bit, exp_tape);
		end
		@(posedge clk_sys);
		cas_relay <= 1'b1;
		for (i = 12; i < 24; i++)
			play_bit(i);
		@(posedge clk_sys);
		status[ST_REWIND] <= 1'b1;
		settle(2);
		check_val("tape_bit (rewind)", tape_bit, 1'b0);
		pulse_tick();
		check_val("tape_bit (rewind)", tape_bit, 1'b0);
		@(posedge clk_sys);
		status[ST_REWIND] <= 1'b0;
		settle(2);
		play_bit(0);
		finish_test("tape playback", err0);
	endtask

	task automatic test_tape_monitor();
		int err0;
		err0 = errors;
		@(posedge clk_sys);
		status[ST_TAPE_MON] <= 1'b1;
		audio_in <= $random(seed);
		settle(1);
		check_audio(1'b1);
		play_bit(1);
		@(posedge clk_sys);
		audio_in <= $random(seed);
		settle(0);
		check_audio(1'b1);
		play_bit(2);
		@(posedge clk_sys);
		status[ST_TAPE_MON] <= 1'b0;
		audio_in <= $random(seed);
		settle(1);
		check_audio(1'b0);
		finish_test("tape monitor", err0);
	endtask

	//==================================================
	// Main sequence and watchdog
	//==================================================
	initial
	begin
		seed           = 53258;
		errors         = 0;
		checks         = 0;
		exp_tape       = 1'b0;
		clk_sys        = 1'b0;
		rst_n          = 1'b0;
		status         = '0;
		// Slot field 3 decodes to slot 1, the reset value
		status[ST_MPI_LO +: 2] = 2'd3;
		user_button    = 1'b0;
		joy1           = '0;
		joy2           = '0;
		joya1          = '0;
		joya2          = '0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ioctl_index    = '0;
		cas_relay      = 1'b0;
		q_tick         = 1'b0;
		audio_in       = '0;
		reset_ack      = 1'b0;
		tape_bytes[0]  = 8'hA5;
		tape_bytes[1]  = 8'h3C;
		tape_bytes[2]  = 8'hC9;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_sys);
		test_status_decode();
		test_joystick();
		test_config_reset();
		test_host_reset();
		test_tape_playback();
		test_tape_monitor();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule
